// ==== rtl/i2cPkg.sv ====
`default_nettype none

package i2cPkg;

   // Fixed slave on the bus
   localparam logic [6:0] DEVICE_ADDRESS = 7'h3C;

   // Counter width of the bit timer, enough for 1023 clocks per bit
   localparam int TIMER_WIDTH = 10;

   // Direction bit appended to the device address
   localparam logic RW_WRITE = 1'b0;
   localparam logic RW_READ  = 1'b1;

   // Level of SDA in an acknowledge slot
   localparam logic ACK  = 1'b0;
   localparam logic NACK = 1'b1; // Also the released line

   // Bus symbol requested for one bit period
   typedef enum logic [2:0]
   {
      SYM_IDLE,
      SYM_START,
      SYM_RESTART,
      SYM_DATA,
      SYM_STOP
   } symbolOp;

   // Kind of register access
   typedef enum logic
   {
      XFER_WRITE,
      XFER_READ
   } xferKind;

   // Sequencer states, one per stage of a transfer
   typedef enum logic [3:0]
   {
      S_IDLE,
      S_START,
      S_DEVW,    // Device address, write direction
      S_REG,     // Register address
      S_WDATA,
      S_RESTART,
      S_DEVR,    // Device address, read direction
      S_RDATA,
      S_STOP,
      S_DONE
   } seqState;

endpackage

`default_nettype wire

// ==== rtl/i2cSymbolIf.sv ====
`default_nettype none

interface i2cSymbolIf;
   import i2cPkg::*;

   symbolOp    symbol;       // Symbol of the current bit period
   logic       run;          // Bit timer enable
   logic       txBit;        // 1 releases SDA
   logic       quarter;
   logic       half;
   logic       threeQuarter;
   logic       periodEnd;
   logic       rxBit;        // SDA sampled at half
   logic       load;
   logic [7:0] loadByte;
   logic       byteEnd;      // Last cycle of the ack slot
   logic       ackBit;

   modport sequencer (output symbol, run, load, loadByte,
                      input periodEnd, byteEnd, ackBit);

   modport timer (input run, output quarter, half, threeQuarter, periodEnd);

   modport driver (input symbol, txBit, quarter, half, threeQuarter, periodEnd,
                   output rxBit);

   modport shifter (input load, loadByte, periodEnd, rxBit,
                    output txBit, byteEnd, ackBit);

endinterface

`default_nettype wire

// ==== rtl/i2cSequencer.sv ====
`default_nettype none

module i2cSequencer
(
   input  logic          CLOCK,
   input  logic          RESET,
   input  logic [1:0]    call,     // Bit 1 write, bit 0 read
   input  logic [7:0]    regAddr,
   input  logic [7:0]    wrData,
   input  logic [7:0]    rxByte,   // Received byte from the shifter
   output logic [7:0]    rdData,
   output logic          done,
   output logic          nack,
   i2cSymbolIf.sequencer bus
);
   import i2cPkg::*;

   seqState state;
   xferKind kind;
   logic    ackMissing;

   assign ackMissing = bus.ackBit != ACK;

   always_ff @(posedge CLOCK or negedge RESET)
   begin
      if (!RESET)
      begin
         state        <= S_IDLE;
         kind         <= XFER_WRITE;
         bus.symbol   <= SYM_IDLE;
         bus.run      <= 1'b0;
         bus.load     <= 1'b0;
         bus.loadByte <= '0;
         rdData       <= '0;
         done         <= 1'b0;
         nack         <= 1'b0;
      end
      else
      begin
         bus.load <= 1'b0;
         done     <= 1'b0;

         // Slave did not acknowledge an address or data byte
         if (bus.byteEnd && ackMissing && state != S_RDATA)
         begin
            nack       <= 1'b1;
            bus.symbol <= SYM_STOP;
            state      <= S_STOP;
         end
         else
         begin
            case (state)
               S_IDLE:
                  if (call != 2'b00)
                  begin
                     kind       <= call[1] ? XFER_WRITE : XFER_READ; // Write wins
                     nack       <= 1'b0;
                     bus.run    <= 1'b1;
                     bus.symbol <= SYM_START;
                     state      <= S_START;
                  end
               S_START:
                  if (bus.periodEnd)
                  begin
                     bus.symbol   <= SYM_DATA;
                     bus.load     <= 1'b1;
                     bus.loadByte <= {DEVICE_ADDRESS, RW_WRITE};
                     state        <= S_DEVW;
                  end
               S_DEVW:
                  if (bus.byteEnd)
                  begin
                     bus.load     <= 1'b1;
                     bus.loadByte <= regAddr;
                     state        <= S_REG;
                  end
               S_REG:
                  if (bus.byteEnd)
                  begin
                     if (kind == XFER_WRITE)
                     begin
                        bus.load     <= 1'b1;
                        bus.loadByte <= wrData;
                        state        <= S_WDATA;
                     end
                     else
                     begin
                        bus.symbol <= SYM_RESTART;
                        state      <= S_RESTART;
                     end
                  end
               S_WDATA:
                  if (bus.byteEnd)
                  begin
                     bus.symbol <= SYM_STOP;
                     state      <= S_STOP;
                  end
               S_RESTART:
                  if (bus.periodEnd)
                  begin
                     bus.symbol   <= SYM_DATA;
                     bus.load     <= 1'b1;
                     bus.loadByte <= {DEVICE_ADDRESS, RW_READ};
                     state        <= S_DEVR;
                  end
               S_DEVR:
                  if (bus.byteEnd)
                  begin
                     bus.load     <= 1'b1;
                     bus.loadByte <= 8'hFF; // SDA released, ack slot sends nack
                     state        <= S_RDATA;
                  end
               S_RDATA:
                  if (bus.byteEnd)
                  begin
                     rdData     <= rxByte;
                     bus.symbol <= SYM_STOP;
                     state      <= S_STOP;
                  end
               S_STOP:
                  if (bus.periodEnd)
                  begin
                     bus.symbol <= SYM_IDLE;
                     bus.run    <= 1'b0;
                     state      <= S_DONE;
                  end
               S_DONE:
               begin
                  done  <= 1'b1;
                  state <= S_IDLE;
               end
               default:
                  state <= S_IDLE;
            endcase
         end
      end
   end

   // One pulse per transfer
   doneSingle: assert property (@(posedge CLOCK) disable iff (!RESET)
      done |=> !done)
      else $error("done high for two cycles");

   // Bus symbols keep the bit-period grid of the timer
   symbolOnGrid: assert property (@(posedge CLOCK) disable iff (!RESET)
      !$stable(bus.symbol) |-> $past(bus.periodEnd) || $past(state) == S_IDLE)
      else $error("symbol changed inside a bit period");

endmodule

`default_nettype wire

// ==== rtl/bitTimer.sv ====
`default_nettype none

module bitTimer
#(
   parameter int BIT_CYCLES = 20
)
(
   input  logic      CLOCK,
   input  logic      RESET,
   i2cSymbolIf.timer bus
);
   import i2cPkg::*;

   localparam logic [TIMER_WIDTH-1:0] QUARTER_COUNT = TIMER_WIDTH'(BIT_CYCLES / 4);
   localparam logic [TIMER_WIDTH-1:0] HALF_COUNT    = TIMER_WIDTH'(BIT_CYCLES / 2);
   localparam logic [TIMER_WIDTH-1:0] THREE_COUNT   = TIMER_WIDTH'(3 * BIT_CYCLES / 4);
   localparam logic [TIMER_WIDTH-1:0] LAST_COUNT    = TIMER_WIDTH'(BIT_CYCLES - 1);

   logic [TIMER_WIDTH-1:0] count;

   if (BIT_CYCLES % 4 != 0 || BIT_CYCLES < 8 || BIT_CYCLES >= (1 << TIMER_WIDTH))
   begin : badBitCycles
      $error("BIT_CYCLES must be a multiple of 4 between 8 and 1023");
   end

   always_ff @(posedge CLOCK or negedge RESET)
   begin
      if (!RESET)
         count <= '0;
      else if (!bus.run)
         count <= '0; // Held at the period start while stopped
      else if (count == LAST_COUNT)
         count <= '0;
      else
         count <= count + 1'b1;
   end

   assign bus.quarter      = bus.run && count == QUARTER_COUNT;
   assign bus.half         = bus.run && count == HALF_COUNT;
   assign bus.threeQuarter = bus.run && count == THREE_COUNT;
   assign bus.periodEnd    = bus.run && count == LAST_COUNT;

   // Strobes follow each other a quarter period apart
   strobesInOrder: assert property (@(posedge CLOCK) disable iff (!RESET)
      bus.quarter |-> ##(BIT_CYCLES / 4) bus.half ##(BIT_CYCLES / 4) bus.threeQuarter
                      ##(BIT_CYCLES / 4 - 1) bus.periodEnd)
      else $error("phase strobes off the quarter grid");

endmodule

`default_nettype wire

// ==== rtl/byteShifter.sv ====
`default_nettype none

module byteShifter
(
   input  logic        CLOCK,
   input  logic        RESET,
   output logic [7:0]  rxByte,  // First eight samples of the byte
   i2cSymbolIf.shifter bus
);
   import i2cPkg::*;

   logic [8:0] txShift;   // Byte plus ack slot, MSB first
   logic [3:0] slot;
   logic       busy;
   logic       lastSlot;

   assign lastSlot = slot == 4'd8;

   // Slot tracking
   always_ff @(posedge CLOCK or negedge RESET)
   begin
      if (!RESET)
      begin
         busy <= 1'b0;
         slot <= '0;
      end
      else if (bus.load)
      begin
         busy <= 1'b1;
         slot <= '0;
      end
      else if (busy && bus.periodEnd)
      begin
         if (lastSlot)
            busy <= 1'b0;
         else
            slot <= slot + 1'b1;
      end
   end

   // Data path, rxBit already holds the sample taken at half
   always_ff @(posedge CLOCK)
   begin
      if (bus.load)
         txShift <= {bus.loadByte, NACK};
      else if (bus.periodEnd)
      begin
         txShift <= {txShift[7:0], 1'b1};
         if (busy && !lastSlot)
            rxByte <= {rxByte[6:0], bus.rxBit};
      end
   end

   assign bus.txBit   = busy ? txShift[8] : 1'b1; // Released between bytes
   assign bus.byteEnd = busy && bus.periodEnd && lastSlot;
   assign bus.ackBit  = bus.rxBit; // Ninth sample at byteEnd

endmodule

`default_nettype wire

// ==== rtl/lineDriver.sv ====
`default_nettype none

module lineDriver
(
   input  logic       CLOCK,
   input  logic       RESET,
   output logic       SCL,
   output logic       sdaLow,   // Pulls the open-drain SDA line low
   input  logic       sdaIn,
   i2cSymbolIf.driver bus
);
   import i2cPkg::*;

   logic [1:0] sdaSync;
   logic       firstQuarter;
   logic       early;         // Before the quarter strobe

   assign early = firstQuarter && !bus.quarter;

   always_ff @(posedge CLOCK or negedge RESET)
   begin
      if (!RESET)
      begin
         sdaSync      <= 2'b11;
         firstQuarter <= 1'b1;
         bus.rxBit    <= 1'b1;
         SCL          <= 1'b1;
         sdaLow       <= 1'b0;
      end
      else
      begin
         sdaSync <= {sdaSync[0], sdaIn};
         if (bus.half)
            bus.rxBit <= sdaSync[1];

         if (bus.symbol == SYM_IDLE || bus.periodEnd)
            firstQuarter <= 1'b1;
         else if (bus.quarter)
            firstQuarter <= 1'b0;

         case (bus.symbol)
            SYM_START, SYM_RESTART:
            begin
               if (early)
                  sdaLow <= 1'b0;
               if (bus.quarter)
                  SCL <= 1'b1;
               if (bus.half)
                  sdaLow <= 1'b1;   // SDA falls while SCL high
            end
            SYM_DATA:
            begin
               // SCL goes low first, SDA follows a cycle later
               if (early)
               begin
                  if (SCL)
                     SCL <= 1'b0;
                  else
                     sdaLow <= ~bus.txBit;
               end
               if (bus.quarter)
                  SCL <= 1'b1;
               if (bus.threeQuarter)
                  SCL <= 1'b0;
            end
            SYM_STOP:
            begin
               if (early)
                  sdaLow <= 1'b1;
               if (bus.quarter)
                  SCL <= 1'b1;
               if (bus.threeQuarter)
                  sdaLow <= 1'b0;   // SDA rises while SCL high
            end
            default:
            begin
               SCL    <= 1'b1;
               sdaLow <= 1'b0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== rtl/i2cRegisterMaster.sv ====
`default_nettype none

module i2cRegisterMaster
#(
   parameter int BIT_CYCLES = 20   // Clocks per bit period
)
(
   input  logic       CLOCK,
   input  logic       RESET,
   input  logic [1:0] call,
   input  logic [7:0] regAddr,
   input  logic [7:0] wrData,
   output logic [7:0] rdData,
   output logic       done,
   output logic       nack,
   output logic       SCL,
   output logic       sdaLow,
   input  logic       sdaIn
);

   i2cSymbolIf bus ();

   logic [7:0] rxByte;

   i2cSequencer i2cSequencer_inst
   (
      .CLOCK   (CLOCK),
      .RESET   (RESET),
      .call    (call),
      .regAddr (regAddr),
      .wrData  (wrData),
      .rxByte  (rxByte),
      .rdData  (rdData),
      .done    (done),
      .nack    (nack),
      .bus     (bus.sequencer)
   );

   bitTimer
   #(
      .BIT_CYCLES (BIT_CYCLES)
   )
   bitTimer_inst
   (
      .CLOCK (CLOCK),
      .RESET (RESET),
      .bus   (bus.timer)
   );

   byteShifter byteShifter_inst
   (
      .CLOCK  (CLOCK),
      .RESET  (RESET),
      .rxByte (rxByte),
      .bus    (bus.shifter)
   );

   // Open-drain pad is formed outside
   lineDriver lineDriver_inst
   (
      .CLOCK  (CLOCK),
      .RESET  (RESET),
      .SCL    (SCL),
      .sdaLow (sdaLow),
      .sdaIn  (sdaIn),
      .bus    (bus.driver)
   );

endmodule

`default_nettype wire

// ==== test/i2cSlaveModel.sv ====
`default_nettype none

module i2cSlaveModel
(
   input  logic SCL,
   input  logic sdaLow,        // Master pull on the open-drain SDA
   input  logic forceNack,     // Withhold the ack of the register byte
   output logic sdaIn,
   output int   startCount,
   output int   restartCount,
   output int   stopCount
);
   timeunit 1ns;
   timeprecision 100ps;
   import i2cPkg::*;

   logic [7:0] mem [0:255];
   logic [7:0] shiftIn;
   logic [7:0] sendShift;      // Read byte, MSB goes out first
   logic [7:0] regPtr;
   logic       pull;           // Slave pull on SDA
   logic       nextPull;       // Applied on the next SCL fall
   logic       onBus;          // Between start and stop
   logic       active;         // Still taking part in this transfer
   logic       readMode;
   logic       acked;
   logic       lastScl;
   logic       lastSda;
   int         slot;
   int         byteIndex;

   // Wired-AND of both open-drain drivers
   assign sdaIn = !(sdaLow || pull);

   initial
   begin
      for (int i = 0; i < 256; i++)
         mem[8'(i)] = 8'(i) ^ 8'hA5;   // Reset content of every register
      startCount   = 0;
      restartCount = 0;
      stopCount    = 0;
      shiftIn      = '0;
      sendShift    = 8'hFF;
      regPtr       = '0;
      pull         = 1'b0;
      nextPull     = 1'b0;
      onBus        = 1'b0;
      active       = 1'b0;
      readMode     = 1'b0;
      acked        = 1'b0;
      lastScl      = 1'b1;
      lastSda      = 1'b1;
      slot         = 0;
      byteIndex    = 0;
   end

   always @(SCL or sdaLow)
   begin
      logic sda;
      sda = !(sdaLow || pull);
      if (SCL === lastScl)
      begin
         // SDA moving while SCL is high marks start or stop
         if (SCL && lastSda && !sda)
         begin
            if (onBus)
               restartCount++;
            else
               startCount++;
            onBus     = 1'b1;
            active    = 1'b1;
            readMode  = 1'b0;
            slot      = 0;
            byteIndex = 0;
            nextPull  = 1'b0;
         end
         else if (SCL && !lastSda && sda)
         begin
            stopCount++;
            onBus  = 1'b0;
            active = 1'b0;
         end
      end
      else if (SCL && active)
      begin
         if (slot < 8)
         begin
            if (!readMode)
               shiftIn = {shiftIn[6:0], sda};
            slot++;
            if (slot == 8 && readMode)
               nextPull = 1'b0;   // Master answers in the ack slot
            else if (slot == 8)
            begin
               case (byteIndex)
                  0: acked = shiftIn[7:1] == DEVICE_ADDRESS;
                  1:
                  begin
                     acked = !forceNack;
                     if (acked)
                        regPtr = shiftIn;
                  end
                  default:
                  begin
                     acked       = 1'b1;
                     mem[regPtr] = shiftIn;
                     regPtr      = regPtr + 8'd1;
                  end
               endcase
               nextPull = acked;
            end
            else if (readMode)
            begin
               sendShift = {sendShift[6:0], 1'b1};
               nextPull  = !sendShift[7];
            end
         end
         else
         begin
            // Ack slot sampled
            slot     = 0;
            nextPull = 1'b0;
            if (readMode || !acked)
               active = 1'b0;   // Wait for the stop
            else if (byteIndex == 0 && shiftIn[0])
            begin
               readMode  = 1'b1;
               sendShift = mem[regPtr];
               nextPull  = !sendShift[7];
            end
            byteIndex++;
         end
      end
      else if (!SCL)
         pull = nextPull;   // SDA only changes while SCL is low
      lastScl = SCL;
      lastSda = !(sdaLow || pull);
   end

endmodule

`default_nettype wire

// ==== test/i2cRegisterMasterTb.sv ====
`default_nettype none

module i2cRegisterMasterTb;
   timeunit 1ns;
   timeprecision 100ps;
   import i2cPkg::*;

   localparam int BIT_CYCLES   = 20;
   localparam int WAIT_LIMIT   = 50 * BIT_CYCLES;
   localparam int WRITE_CYCLES = 29 * BIT_CYCLES + 2;
   localparam int READ_CYCLES  = 39 * BIT_CYCLES + 2;

   logic        CLOCK;
   logic        RESET;
   logic [1:0]  call;
   logic [7:0]  regAddr;
   logic [7:0]  wrData;
   logic [7:0]  rdData;
   logic        done;
   logic        nack;
   logic        SCL;
   logic        sdaLow;
   logic        sdaIn;
   logic        forceNack;
   int          startCount;
   int          restartCount;
   int          stopCount;
   logic [7:0]  shadow [0:255];   // Expected register contents
   logic [31:0] lfsr;
   int          transferCount;

   i2cRegisterMaster
   #(
      .BIT_CYCLES (BIT_CYCLES)
   )
   i2cRegisterMaster_inst
   (
      .CLOCK   (CLOCK),
      .RESET   (RESET),
      .call    (call),
      .regAddr (regAddr),
      .wrData  (wrData),
      .rdData  (rdData),
      .done    (done),
      .nack    (nack),
      .SCL     (SCL),
      .sdaLow  (sdaLow),
      .sdaIn   (sdaIn)
   );

   i2cSlaveModel slave
   (
      .SCL          (SCL),
      .sdaLow       (sdaLow),
      .forceNack    (forceNack),
      .sdaIn        (sdaIn),
      .startCount   (startCount),
      .restartCount (restartCount),
      .stopCount    (stopCount)
   );

   always #2 CLOCK = ~CLOCK;

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
      if (got !== expected)
      begin
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
         $display("Regression failed");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   // Right-shifting Galois form with taps 32 22 2 1
   function automatic logic [31:0] stepLfsr(input logic [31:0] state);
      return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
   endfunction

   task automatic takeRandomByte(output logic [7:0] value);
      value = '0;
      for (int i = 0; i < 8; i++)
      begin
         value = {value[6:0], lfsr[0]};
         lfsr  = stepLfsr(lfsr);
      end
   endtask

   task automatic runTransfer(input xferKind kind, input logic [7:0] regIndex,
                              input logic [7:0] data, input logic nackIn,
                              input logic [7:0] expected);
      int cycles;
      int startsBefore;
      int restartsBefore;
      int stopsBefore;
      transferCount++;
      checkValue("SCL", 32'(SCL), 32'd1);   // Idle bus before the call
      checkValue("sdaLow", 32'(sdaLow), 32'd0);
      startsBefore   = startCount;
      restartsBefore = restartCount;
      stopsBefore    = stopCount;
      regAddr   = regIndex;
      wrData    = data;
      forceNack = nackIn;
      call      = kind == XFER_WRITE ? 2'b10 : 2'b01;
      cycles    = 0;
      do
      begin
         @(posedge CLOCK);
         #1;
         call = 2'b00;
         cycles++;
      end
      while (done !== 1'b1 && cycles < WAIT_LIMIT);
      if (done !== 1'b1)
      begin
         $display("Timeout: transfer %0d (%s of register 0x%02h) never raised done",
                  transferCount, kind == XFER_WRITE ? "write" : "read", regIndex);
         $display("Regression failed");
         $fatal(1, "Transfer hung");
      end
      checkValue("nack", 32'(nack), 32'(nackIn));
      if (!nackIn)
      begin
         checkValue("done latency", cycles, kind == XFER_WRITE ? WRITE_CYCLES : READ_CYCLES);
         if (kind == XFER_WRITE)
            shadow[regIndex] = data;
         else
            checkValue("rdData", 32'(rdData), 32'(expected));
      end
      checkValue("slave start count", startCount - startsBefore, 1);
      checkValue("slave restart count", restartCount - restartsBefore,
                 kind == XFER_READ && !nackIn ? 1 : 0);
      checkValue("slave stop count", stopCount - stopsBefore, 1);
      forceNack = 1'b0;
      checkValue("SCL", 32'(SCL), 32'd1);
      checkValue("sdaLow", 32'(sdaLow), 32'd0);
   endtask

   initial
   begin
      int         fd;
      int         fields;
      string      line;
      int         kindIn;
      int         regIn;
      int         dataIn;
      int         expectIn;
      int         nackFlag;
      logic [7:0] randReg;
      logic [7:0] randData;
      CLOCK         = 1'b0;
      RESET         = 1'b0;
      call          = 2'b00;
      regAddr       = '0;
      wrData        = '0;
      forceNack     = 1'b0;
      transferCount = 0;
      lfsr          = 32'h8e0f_c306;
      for (int i = 0; i < 256; i++)
         shadow[8'(i)] = 8'(i) ^ 8'hA5;
      repeat (5) @(posedge CLOCK);
      #1;
      RESET = 1'b1;
      @(posedge CLOCK);
      #1;
      checkValue("done", 32'(done), 32'd0);
      checkValue("nack", 32'(nack), 32'd0);

      fd = $fopen("test/i2c_testdata.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the test data file test/i2c_testdata.txt");
         $display("Regression failed");
         $fatal(1, "No stimulus");
      end
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() < 2 || line[0] == "#")
            continue;   // Blank or comment line
         fields = $sscanf(line, "%h %h %h %h %h", kindIn, regIn, dataIn, expectIn, nackFlag);
         if (fields != 5)
         begin
            $display("Malformed line in the test data file: %s", line);
            $display("Regression failed");
            $fatal(1, "Bad stimulus");
         end
         runTransfer(kindIn == 0 ? XFER_WRITE : XFER_READ, 8'(regIn), 8'(dataIn),
                     nackFlag != 0, 8'(expectIn));
      end
      $fclose(fd);

      // Random write and read-back pairs
      repeat (16)
      begin
         takeRandomByte(randReg);
         takeRandomByte(randData);
         runTransfer(XFER_WRITE, randReg, randData, 1'b0, 8'h00);
         runTransfer(XFER_READ, randReg, 8'h00, 1'b0, shadow[randReg]);
      end

      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/i2c_testdata.txt ====
# kind (0 write, 1 read), register, write data, expected read data, forced nack
# All values hex; an unwritten register reads as its index XOR A5
0 10 5A 00 0
1 10 00 5A 0
0 3C C3 00 0
1 3C 00 C3 0
1 20 00 85 0
1 FF 00 5A 0
0 44 12 00 1
1 44 00 E1 0
1 07 00 A2 1
1 07 00 A2 0
0 00 FF 00 0
1 00 00 FF 0
0 81 00 00 0
1 81 00 00 0

// ==== tb.f ====
rtl/i2cPkg.sv
rtl/i2cSymbolIf.sv
rtl/i2cSequencer.sv
rtl/bitTimer.sv
rtl/byteShifter.sv
rtl/lineDriver.sv
rtl/i2cRegisterMaster.sv
test/i2cSlaveModel.sv
test/i2cRegisterMasterTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the I2C register master regression with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -j 0 -f tb.f \
   --top-module i2cRegisterMasterTb -o simv || exit 1
./obj_dir/simv 2>&1 | tee sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0
